/* include/pwrmgr_consts.svh */
`ifndef PWRMGR_CONSTS_SVH
`define PWRMGR_CONSTS_SVH

// power domains, index 0 is always-on
`define PWR_DOMAINS 2

// gated ip clocks, main and io
`define CLK_DOMAINS 2

// peripheral hardware reset requests
`define NUM_HW_REQS 2

// reset request word, hw requests sit in the low bits
`define RST_REQ_W 6
`define RST_NDM_IDX 2
`define RST_SW_IDX 3
`define RST_ESC_IDX 4
`define RST_MAINPWR_IDX 5

`endif

/* logic/pwrmgr_pkg.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

package pwrmgr_pkg;

  // fast sequencer states
  typedef enum logic [4:0] {
    LowPower,
    EnableClocks,
    ReleaseRst,
    OtpInit,
    LcInit,
    AckPwrUp,
    RomCheckDone,
    RomCheckGood,
    Active,
    DisClks,
    FallThrough,
    NvmIdleChk,
    LowPowerPrep,
    ReqPwrDn,
    NvmShutDown,
    ResetPrep,
    ResetWait
  } fast_state_e;

  // reset hint kept by the reset controller
  typedef enum logic [1:0] {
    ResetNone,
    LowPwrEntry,
    HwReq,
    ResetUndefined
  } reset_cause_e;

  // order from the sequencer to the reset controller
  typedef enum logic [2:0] {
    Hold,
    Release,
    LowPwrPrep,
    RstPrep,
    RstWait,
    ClearCause,
    Undefine
  } rst_cmd_e;

  // field view of the request word, msb first
  typedef struct packed {
    logic                    main_pwr;
    logic                    esc;
    logic                    sw;
    logic                    ndm;
    logic [`NUM_HW_REQS-1:0] hw;
  } rst_reqs_t;

  // raw view for the any-request check
  typedef union packed {
    logic [`RST_REQ_W-1:0] raw;
    rst_reqs_t             req;
  } rst_reqs_u;

endpackage

`default_nettype wire

/* logic/pwrmgr_rst_if.sv */
`default_nettype none

interface pwrmgr_rst_if;

  // command for the next reset register update
  pwrmgr_pkg::rst_cmd_e cmd;

  // request classes decoded from the request word
  logic any_req;
  logic direct_req;
  logic main_pwr_req;

  // reset state seen by the sequencer
  logic lc_released;
  logic rst_valid;
  logic cause_lowpwr;

  modport fsm (
    output cmd,
    input  any_req, direct_req, main_pwr_req,
    input  lc_released, rst_valid, cause_lowpwr
  );

  modport ctrl (
    input  cmd,
    output any_req, direct_req, main_pwr_req,
    output lc_released, rst_valid, cause_lowpwr
  );

endinterface

`default_nettype wire

/* logic/pwrmgr_clk_ctrl.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

module pwrmgr_clk_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     clk_en_req_i,
  input  wire logic [`CLK_DOMAINS-1:0]  clk_en_status_i,
  output logic      [`CLK_DOMAINS-1:0]  ip_clk_en_o,
  output logic                          clks_on_o,
  output logic                          clks_off_o
);

  logic ip_clk_en_q;

  // single enable for all gated ip clocks
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ip_clk_en_q <= 1'b0;
    end else begin
      ip_clk_en_q <= clk_en_req_i;
    end
  end

  // main and io only switch as part of the power sequence
  assign ip_clk_en_o = {`CLK_DOMAINS{ip_clk_en_q}};

  // enabled and every clock manager status confirms it
  assign clks_on_o = ip_clk_en_q & (&clk_en_status_i);

  // disabled and every status has dropped
  assign clks_off_o = ~ip_clk_en_q & ~(|clk_en_status_i);

endmodule

`default_nettype wire

/* logic/pwrmgr_rst_ctrl.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

module pwrmgr_rst_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire pwrmgr_pkg::rst_reqs_u    reset_reqs_i,
  input  wire logic                     lc_hw_debug_en_i,
  input  wire logic                     main_pd_ni,
  input  wire logic [`PWR_DOMAINS-1:0]  rst_lc_src_ni,
  input  wire logic [`PWR_DOMAINS-1:0]  rst_sys_src_ni,
  pwrmgr_rst_if.ctrl                    rst_if,
  output logic      [`PWR_DOMAINS-1:0]  rst_lc_req_o,
  output logic      [`PWR_DOMAINS-1:0]  rst_sys_req_o,
  output pwrmgr_pkg::reset_cause_e      reset_cause_o,
  output logic                          clr_slow_req_o
);

  logic [`PWR_DOMAINS-1:0] rst_lc_req_q, rst_lc_req_d;
  logic [`PWR_DOMAINS-1:0] rst_sys_req_q, rst_sys_req_d;
  pwrmgr_pkg::reset_cause_e reset_cause_q, reset_cause_d;
  logic hw_req;
  logic sys_rst_set;
  logic pd_rsts_asserted;
  logic all_rsts_match;

  // request classes
  assign rst_if.any_req      = |reset_reqs_i.raw;
  assign rst_if.direct_req   = reset_reqs_i.req.esc | reset_reqs_i.req.main_pwr;
  assign rst_if.main_pwr_req = reset_reqs_i.req.main_pwr;
  assign hw_req              = |reset_reqs_i.req.hw;

  // ndm only resets the system while hw debug is off
  assign sys_rst_set = hw_req | reset_reqs_i.req.sw | rst_if.direct_req |
                       (reset_reqs_i.req.ndm & ~lc_hw_debug_en_i);

  // index 0 is always-on, the rest may be powered down
  assign pd_rsts_asserted = ~(|rst_lc_src_ni[`PWR_DOMAINS-1:1]) &
                            ~(|rst_sys_src_ni[`PWR_DOMAINS-1:1]);

  // every source reset agrees with its request
  assign all_rsts_match = (rst_lc_src_ni == ~rst_lc_req_q) &
                          (rst_sys_src_ni == ~rst_sys_req_q);

  always_comb begin
    rst_lc_req_d  = rst_lc_req_q;
    rst_sys_req_d = rst_sys_req_q;
    reset_cause_d = reset_cause_q;
    unique case (rst_if.cmd)
      pwrmgr_pkg::Release: begin
        rst_lc_req_d  = '0;
        rst_sys_req_d = '0;
      end
      pwrmgr_pkg::LowPwrPrep: begin
        reset_cause_d = pwrmgr_pkg::LowPwrEntry;
        // off domains reset only when main power goes away
        rst_lc_req_d[`PWR_DOMAINS-1:1]  = {(`PWR_DOMAINS-1){~main_pd_ni}};
        rst_sys_req_d[`PWR_DOMAINS-1:1] = {(`PWR_DOMAINS-1){~main_pd_ni}};
      end
      pwrmgr_pkg::RstPrep: begin
        reset_cause_d = pwrmgr_pkg::HwReq;
        rst_lc_req_d  = '1;
        rst_sys_req_d = {`PWR_DOMAINS{sys_rst_set}};
      end
      pwrmgr_pkg::RstWait: begin
        rst_lc_req_d = '1;
      end
      pwrmgr_pkg::ClearCause: begin
        reset_cause_d = pwrmgr_pkg::ResetNone;
      end
      pwrmgr_pkg::Undefine: begin
        reset_cause_d = pwrmgr_pkg::ResetUndefined;
      end
      default: begin
        // hold keeps everything as is
        reset_cause_d = reset_cause_q;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_lc_req_q  <= '1;
      rst_sys_req_q <= '1;
      reset_cause_q <= pwrmgr_pkg::ResetUndefined;
    end else begin
      rst_lc_req_q  <= rst_lc_req_d;
      rst_sys_req_q <= rst_sys_req_d;
      reset_cause_q <= reset_cause_d;
    end
  end

  // low power path depends on domain power down, reset path on every domain
  always_comb begin
    unique case (reset_cause_q)
      pwrmgr_pkg::LowPwrEntry: rst_if.rst_valid = main_pd_ni | pd_rsts_asserted;
      pwrmgr_pkg::HwReq:       rst_if.rst_valid = all_rsts_match;
      default:                 rst_if.rst_valid = 1'b0;
    endcase
  end

  assign rst_if.lc_released  = &rst_lc_src_ni;
  assign rst_if.cause_lowpwr = (reset_cause_q == pwrmgr_pkg::LowPwrEntry);

  // main power request lives in the por domain and must be cleared explicitly
  assign clr_slow_req_o = (rst_if.cmd == pwrmgr_pkg::RstWait) & rst_if.main_pwr_req;

  assign rst_lc_req_o  = rst_lc_req_q;
  assign rst_sys_req_o = rst_sys_req_q;
  assign reset_cause_o = reset_cause_q;

endmodule

`default_nettype wire

/* logic/pwrmgr_fast_fsm.sv */
`default_nettype none

module pwrmgr_fast_fsm (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  // slow fsm handshake
  input  wire logic   req_pwrup_i,
  input  wire logic   wake_cause_i,
  output logic        ack_pwrup_o,
  output logic        req_pwrdn_o,
  input  wire logic   ack_pwrdn_i,
  input  wire logic   low_power_entry_i,
  // otp and life cycle
  output logic        otp_init_o,
  input  wire logic   otp_done_i,
  input  wire logic   otp_idle_i,
  output logic        lc_init_o,
  input  wire logic   lc_done_i,
  input  wire logic   lc_idle_i,
  input  wire logic   flash_idle_i,
  // rom check
  input  wire logic   rom_done_i,
  input  wire logic   rom_good_i,
  // clock controller
  output logic        clk_en_req_o,
  input  wire logic   clks_on_i,
  input  wire logic   clks_off_i,
  pwrmgr_rst_if.fsm   rst_if,
  // indications
  output logic        wkup_o,
  output logic        fall_through_o,
  output logic        abort_o,
  output logic        clr_hint_o,
  output logic        clr_cfg_lock_o,
  output logic        low_power_o,
  output logic        fetch_en_o
);

  pwrmgr_pkg::fast_state_e state_q, state_d;
  logic ack_pwrup_q, ack_pwrup_d;
  logic req_pwrdn_q, req_pwrdn_d;
  logic reset_ongoing_q, reset_ongoing_d;
  logic low_power_q, low_power_d;
  logic fetch_en_q, fetch_en_d;
  logic otp_init, lc_init;
  logic nvm_idle;

  assign nvm_idle = otp_idle_i & lc_idle_i & flash_idle_i;

  always_comb begin
    state_d         = state_q;
    ack_pwrup_d     = ack_pwrup_q;
    req_pwrdn_d     = req_pwrdn_q;
    reset_ongoing_d = reset_ongoing_q;
    low_power_d     = low_power_q;
    fetch_en_d      = fetch_en_q;
    otp_init        = 1'b0;
    lc_init         = 1'b0;
    clk_en_req_o    = 1'b0;
    wkup_o          = 1'b0;
    fall_through_o  = 1'b0;
    abort_o         = 1'b0;
    clr_hint_o      = 1'b0;
    clr_cfg_lock_o  = 1'b0;
    rst_if.cmd      = pwrmgr_pkg::Hold;
    unique case (state_q)
      pwrmgr_pkg::LowPower: begin
        // a pending reset cycle powers up without the slow fsm
        if (req_pwrup_i || reset_ongoing_q) begin
          state_d = pwrmgr_pkg::EnableClocks;
        end
      end
      pwrmgr_pkg::EnableClocks: begin
        clk_en_req_o = 1'b1;
        if (clks_on_i) begin
          state_d = pwrmgr_pkg::ReleaseRst;
        end
      end
      pwrmgr_pkg::ReleaseRst: begin
        clk_en_req_o = 1'b1;
        rst_if.cmd   = pwrmgr_pkg::Release;
        if (rst_if.lc_released) begin
          state_d = pwrmgr_pkg::OtpInit;
        end
      end
      pwrmgr_pkg::OtpInit: begin
        clk_en_req_o = 1'b1;
        otp_init     = 1'b1;
        if (otp_done_i) begin
          state_d = pwrmgr_pkg::LcInit;
        end
      end
      pwrmgr_pkg::LcInit: begin
        clk_en_req_o = 1'b1;
        lc_init      = 1'b1;
        if (lc_done_i) begin
          state_d = pwrmgr_pkg::AckPwrUp;
        end
      end
      pwrmgr_pkg::AckPwrUp: begin
        clk_en_req_o = 1'b1;
        // ack only when the slow fsm actually asked
        ack_pwrup_d  = ~reset_ongoing_q;
        if (!req_pwrup_i || reset_ongoing_q) begin
          ack_pwrup_d     = 1'b0;
          clr_cfg_lock_o  = 1'b1;
          // woken from a real low power entry
          wkup_o          = wake_cause_i & rst_if.cause_lowpwr;
          reset_ongoing_d = 1'b0;
          state_d         = pwrmgr_pkg::RomCheckDone;
        end
      end
      pwrmgr_pkg::RomCheckDone: begin
        clk_en_req_o = 1'b1;
        low_power_d  = 1'b0;
        rst_if.cmd   = pwrmgr_pkg::ClearCause;
        if (rom_done_i) begin
          state_d = pwrmgr_pkg::RomCheckGood;
        end
      end
      pwrmgr_pkg::RomCheckGood: begin
        clk_en_req_o = 1'b1;
        if (rom_good_i) begin
          state_d = pwrmgr_pkg::Active;
        end
      end
      pwrmgr_pkg::Active: begin
        clk_en_req_o = 1'b1;
        // processor fetches only here
        fetch_en_d   = 1'b1;
        if (rst_if.any_req || low_power_entry_i) begin
          fetch_en_d = 1'b0;
          rst_if.cmd = pwrmgr_pkg::Undefine;
          state_d    = pwrmgr_pkg::DisClks;
        end
      end
      pwrmgr_pkg::DisClks: begin
        low_power_d = ~rst_if.any_req;
        if (clks_off_i) begin
          state_d = rst_if.any_req ? pwrmgr_pkg::NvmShutDown : pwrmgr_pkg::FallThrough;
        end else if (rst_if.direct_req) begin
          // escalation and main power skip the clock handshake
          state_d = pwrmgr_pkg::NvmShutDown;
        end
      end
      pwrmgr_pkg::FallThrough: begin
        clr_hint_o = 1'b1;
        // processor left wfi before the entry completed
        if (!low_power_entry_i) begin
          clk_en_req_o   = 1'b1;
          wkup_o         = 1'b1;
          fall_through_o = 1'b1;
          state_d        = pwrmgr_pkg::RomCheckDone;
        end else begin
          state_d = pwrmgr_pkg::NvmIdleChk;
        end
      end
      pwrmgr_pkg::NvmIdleChk: begin
        if (nvm_idle) begin
          state_d = pwrmgr_pkg::LowPowerPrep;
        end else begin
          clk_en_req_o = 1'b1;
          wkup_o       = 1'b1;
          abort_o      = 1'b1;
          state_d      = pwrmgr_pkg::RomCheckDone;
        end
      end
      pwrmgr_pkg::LowPowerPrep: begin
        rst_if.cmd = pwrmgr_pkg::LowPwrPrep;
        if (rst_if.rst_valid) begin
          state_d = pwrmgr_pkg::ReqPwrDn;
        end
      end
      pwrmgr_pkg::ReqPwrDn: begin
        req_pwrdn_d = 1'b1;
        if (ack_pwrdn_i) begin
          req_pwrdn_d = 1'b0;
          state_d     = pwrmgr_pkg::LowPower;
        end
      end
      pwrmgr_pkg::NvmShutDown: begin
        clr_hint_o      = 1'b1;
        reset_ongoing_d = 1'b1;
        state_d         = pwrmgr_pkg::ResetPrep;
      end
      pwrmgr_pkg::ResetPrep: begin
        rst_if.cmd = pwrmgr_pkg::RstPrep;
        state_d    = pwrmgr_pkg::ResetWait;
      end
      pwrmgr_pkg::ResetWait: begin
        rst_if.cmd = pwrmgr_pkg::RstWait;
        // stuck here while main power request stays set
        if (rst_if.rst_valid && !rst_if.main_pwr_req) begin
          state_d = pwrmgr_pkg::LowPower;
        end
      end
      default: begin
        state_d = pwrmgr_pkg::LowPower;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= pwrmgr_pkg::LowPower;
      ack_pwrup_q     <= 1'b0;
      req_pwrdn_q     <= 1'b0;
      reset_ongoing_q <= 1'b0;
      low_power_q     <= 1'b1;
      fetch_en_q      <= 1'b0;
      otp_init_o      <= 1'b0;
      lc_init_o       <= 1'b0;
    end else begin
      state_q         <= state_d;
      ack_pwrup_q     <= ack_pwrup_d;
      req_pwrdn_q     <= req_pwrdn_d;
      reset_ongoing_q <= reset_ongoing_d;
      low_power_q     <= low_power_d;
      fetch_en_q      <= fetch_en_d;
      otp_init_o      <= otp_init;
      lc_init_o       <= lc_init;
    end
  end

  assign ack_pwrup_o = ack_pwrup_q;
  assign req_pwrdn_o = req_pwrdn_q;
  assign low_power_o = low_power_q;
  assign fetch_en_o  = fetch_en_q;

endmodule

`default_nettype wire

/* logic/pwrmgr_top.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

module pwrmgr_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // slow fsm
  input  wire logic                     req_pwrup_i,
  input  wire logic                     wake_cause_i,
  output logic                          ack_pwrup_o,
  output logic                          req_pwrdn_o,
  input  wire logic                     ack_pwrdn_i,
  input  wire logic                     low_power_entry_i,
  input  wire logic                     main_pd_ni,
  output logic                          clr_slow_req_o,
  // reset requests and reset manager
  input  wire logic [`RST_REQ_W-1:0]    reset_reqs_i,
  input  wire logic                     lc_hw_debug_en_i,
  input  wire logic [`PWR_DOMAINS-1:0]  rst_lc_src_ni,
  input  wire logic [`PWR_DOMAINS-1:0]  rst_sys_src_ni,
  output logic      [`PWR_DOMAINS-1:0]  rst_lc_req_o,
  output logic      [`PWR_DOMAINS-1:0]  rst_sys_req_o,
  output pwrmgr_pkg::reset_cause_e      reset_cause_o,
  // clock manager
  input  wire logic [`CLK_DOMAINS-1:0]  clk_en_status_i,
  output logic      [`CLK_DOMAINS-1:0]  ip_clk_en_o,
  // otp, life cycle, flash, rom
  output logic                          otp_init_o,
  input  wire logic                     otp_done_i,
  input  wire logic                     otp_idle_i,
  output logic                          lc_init_o,
  input  wire logic                     lc_done_i,
  input  wire logic                     lc_idle_i,
  input  wire logic                     flash_idle_i,
  input  wire logic                     rom_done_i,
  input  wire logic                     rom_good_i,
  // indications
  output logic                          wkup_o,
  output logic                          fall_through_o,
  output logic                          abort_o,
  output logic                          clr_hint_o,
  output logic                          clr_cfg_lock_o,
  output logic                          low_power_o,
  output logic                          fetch_en_o
);

  logic clk_en_req;
  logic clks_on;
  logic clks_off;

  // sequencer to reset controller
  pwrmgr_rst_if rst_if ();

  pwrmgr_fast_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_pwrup_i       (req_pwrup_i),
    .wake_cause_i      (wake_cause_i),
    .ack_pwrup_o       (ack_pwrup_o),
    .req_pwrdn_o       (req_pwrdn_o),
    .ack_pwrdn_i       (ack_pwrdn_i),
    .low_power_entry_i (low_power_entry_i),
    .otp_init_o        (otp_init_o),
    .otp_done_i        (otp_done_i),
    .otp_idle_i        (otp_idle_i),
    .lc_init_o         (lc_init_o),
    .lc_done_i         (lc_done_i),
    .lc_idle_i         (lc_idle_i),
    .flash_idle_i      (flash_idle_i),
    .rom_done_i        (rom_done_i),
    .rom_good_i        (rom_good_i),
    .clk_en_req_o      (clk_en_req),
    .clks_on_i         (clks_on),
    .clks_off_i        (clks_off),
    .rst_if            (rst_if.fsm),
    .wkup_o            (wkup_o),
    .fall_through_o    (fall_through_o),
    .abort_o           (abort_o),
    .clr_hint_o        (clr_hint_o),
    .clr_cfg_lock_o    (clr_cfg_lock_o),
    .low_power_o       (low_power_o),
    .fetch_en_o        (fetch_en_o)
  );

  pwrmgr_rst_ctrl u_rst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .reset_reqs_i     (reset_reqs_i),
    .lc_hw_debug_en_i (lc_hw_debug_en_i),
    .main_pd_ni       (main_pd_ni),
    .rst_lc_src_ni    (rst_lc_src_ni),
    .rst_sys_src_ni   (rst_sys_src_ni),
    .rst_if           (rst_if.ctrl),
    .rst_lc_req_o     (rst_lc_req_o),
    .rst_sys_req_o    (rst_sys_req_o),
    .reset_cause_o    (reset_cause_o),
    .clr_slow_req_o   (clr_slow_req_o)
  );

  pwrmgr_clk_ctrl u_clk (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clk_en_req_i    (clk_en_req),
    .clk_en_status_i (clk_en_status_i),
    .ip_clk_en_o     (ip_clk_en_o),
    .clks_on_o       (clks_on),
    .clks_off_o      (clks_off)
  );

endmodule

`default_nettype wire

/* sim/pwrmgr_assertions.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

module pwrmgr_assertions (
  input wire logic                    clk_i,
  input wire logic                    rst_ni,
  input wire logic                    req_pwrup_i,
  input wire logic                    ack_pwrup_o,
  input wire logic                    req_pwrdn_o,
  input wire logic                    fetch_en_o,
  input wire logic [`CLK_DOMAINS-1:0] ip_clk_en_o
);

  // read by the testbench for its closing line
  int fail_count = 0;

  // processor never fetches while power down is requested
  fetch_vs_pwrdn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fetch_en_o && req_pwrdn_o))
  else begin
    fail_count++;
    $error("fetch enable and power down request high together");
  end

  // ack only answers a request seen the cycle before
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_pwrup_o |-> $past(req_pwrup_i))
  else begin
    fail_count++;
    $error("power up ack without a preceding request");
  end

  // all gated clocks run while fetching
  fetch_needs_clks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_en_o |-> (&ip_clk_en_o))
  else begin
    fail_count++;
    $error("fetch enable high with a gated clock off");
  end

endmodule

bind pwrmgr_top pwrmgr_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_pwrup_i (req_pwrup_i),
  .ack_pwrup_o (ack_pwrup_o),
  .req_pwrdn_o (req_pwrdn_o),
  .fetch_en_o  (fetch_en_o),
  .ip_clk_en_o (ip_clk_en_o)
);

`default_nettype wire

/* sim/tb_pwrmgr.sv */
`default_nettype none

`include "pwrmgr_consts.svh"

module tb_pwrmgr;

  localparam int TMO = 200;
  localparam int W_FETCH_LOW = 0;
  localparam int W_PWRDN_HIGH = 1;
  localparam int W_PWRDN_LOW = 2;
  localparam int W_CAUSE_HW = 3;
  localparam int W_CLR_SLOW = 4;

  logic clk_i, rst_ni;
  logic req_pwrup_i, wake_cause_i, ack_pwrdn_i, low_power_entry_i, main_pd_ni;
  logic [`RST_REQ_W-1:0] reset_reqs_i;
  logic lc_hw_debug_en_i;
  logic [`PWR_DOMAINS-1:0] rst_lc_src_ni, rst_sys_src_ni;
  logic [`CLK_DOMAINS-1:0] clk_en_status_i;
  logic otp_done_i, otp_idle_i, lc_done_i, lc_idle_i, flash_idle_i;
  logic rom_done_i, rom_good_i;
  logic ack_pwrup_o, req_pwrdn_o, clr_slow_req_o, otp_init_o, lc_init_o;
  logic [`PWR_DOMAINS-1:0] rst_lc_req_o, rst_sys_req_o;
  pwrmgr_pkg::reset_cause_e reset_cause_o;
  logic [`CLK_DOMAINS-1:0] ip_clk_en_o;
  logic wkup_o, fall_through_o, abort_o, clr_hint_o, clr_cfg_lock_o;
  logic low_power_o, fetch_en_o;

  int errors = 0;
  int timeouts = 0;
  int wkup_cnt = 0;
  int ft_cnt = 0;
  int abort_cnt = 0;
  int lock_cnt = 0;
  int hint_cnt = 0;
  logic [31:0] rng = 32'h3563644a;
  logic [2:0] otp_cnt, lc_cnt, rom_cnt;

  pwrmgr_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // pulses counted where they are sampled by the flops too
  always @(posedge clk_i) begin
    if (rst_ni) begin
      wkup_cnt  <= wkup_cnt + int'(wkup_o);
      ft_cnt    <= ft_cnt + int'(fall_through_o);
      abort_cnt <= abort_cnt + int'(abort_o);
      lock_cnt  <= lock_cnt + int'(clr_cfg_lock_o);
      hint_cnt  <= hint_cnt + int'(clr_hint_o);
    end
  end

  // clock manager, reset manager, otp, lc and rom models
  always @(negedge clk_i) begin
    rng = next_rand(rng);
    clk_en_status_i <= ip_clk_en_o;
    rst_lc_src_ni   <= ~rst_lc_req_o;
    rst_sys_src_ni  <= ~rst_sys_req_o;
    if (!otp_init_o) begin
      otp_done_i <= 1'b0;
      otp_cnt    <= rng[2:0];
    end else if (otp_cnt == 0) begin
      otp_done_i <= 1'b1;
    end else begin
      otp_cnt <= otp_cnt - 1;
    end
    if (!lc_init_o) begin
      lc_done_i <= 1'b0;
      lc_cnt    <= rng[5:3];
    end else if (lc_cnt == 0) begin
      lc_done_i <= 1'b1;
    end else begin
      lc_cnt <= lc_cnt - 1;
    end
    // rom check restarts with every lc init
    if (lc_init_o) begin
      rom_done_i <= 1'b0;
      rom_good_i <= 1'b0;
      rom_cnt    <= rng[8:6];
    end else if (rom_cnt != 0) begin
      rom_cnt <= rom_cnt - 1;
    end else if (!rom_done_i) begin
      rom_done_i <= 1'b1;
      rom_cnt    <= rng[10:9];
    end else begin
      rom_good_i <= 1'b1;
    end
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic bit cond_met(input int which);
    case (which)
      W_FETCH_LOW:  return !fetch_en_o;
      W_PWRDN_HIGH: return req_pwrdn_o;
      W_PWRDN_LOW:  return !req_pwrdn_o;
      W_CAUSE_HW:   return reset_cause_o == pwrmgr_pkg::HwReq;
      default:      return clr_slow_req_o;
    endcase
  endfunction

  task automatic wait_for(input int which, input string what);
    int n;
    for (n = 0; n < TMO && !cond_met(which); n++) begin
      @(negedge clk_i);
    end
    if (!cond_met(which)) begin
      timeouts++;
      $display("timeout at %0t while waiting for %s", $time, what);
    end
  endtask

  // walks one power up and checks the event order
  task automatic power_up(input bit via_slow, input bit exp_wake);
    int n;
    int stage;
    int wk0;
    int lk0;
    bit done;
    stage = 0;
    done  = 1'b0;
    wk0   = wkup_cnt;
    lk0   = lock_cnt;
    if (via_slow) begin
      req_pwrup_i = 1'b1;
    end
    for (n = 0; n < TMO && !done; n++) begin
      @(negedge clk_i);
      if (stage == 0 && ip_clk_en_o == '1) stage = 1;
      if (stage == 1 && rst_lc_req_o == '0) stage = 2;
      if (otp_init_o && stage < 3) begin
        if (stage == 2) stage = 3;
        else check_val(stage, 2, "otp init before reset release");
      end
      if (lc_init_o && stage < 4) begin
        if (stage == 3) stage = 4;
        else check_val(stage, 3, "lc init before otp init");
      end
      if (ack_pwrup_o) begin
        if (!via_slow) check_val(ack_pwrup_o, 0, "ack raised on reset path");
        else if (stage == 4) begin
          stage = 5;
          req_pwrup_i = 1'b0;
        end else if (stage < 4) check_val(stage, 4, "ack before lc init");
      end
      if (fetch_en_o) done = 1'b1;
    end
    if (!done) begin
      timeouts++;
      $display("timeout at %0t while waiting for fetch enable", $time);
    end else begin
      check_val(stage, via_slow ? 5 : 4, "power up stage");
      check_val({rom_done_i, rom_good_i}, 2'b11, "rom inputs at fetch");
      check_val(low_power_o, 0, "low power at fetch");
      check_val(ack_pwrup_o, 0, "ack at fetch");
      check_val(wkup_cnt - wk0, exp_wake, "wake pulses on power up");
      check_val(lock_cnt - lk0, 1, "config lock clear pulses");
    end
  endtask

  task automatic run_lowpwr(input logic pd, input logic [2:0] idle, input logic lpe,
                            input logic [1:0] exp_sys, input logic exp_ab,
                            input logic exp_ft);
    int n;
    int ab0, ft0, wk0, ht0;
    ab0 = abort_cnt;
    ft0 = ft_cnt;
    wk0 = wkup_cnt;
    ht0 = hint_cnt;
    main_pd_ni = pd;
    {otp_idle_i, lc_idle_i, flash_idle_i} = idle;
    low_power_entry_i = 1'b1;
    wait_for(W_FETCH_LOW, "fetch enable to drop");
    if (timeouts != 0) return;
    // level seen when the clocks are off
    low_power_entry_i = lpe;
    if (exp_ft || exp_ab) begin
      for (n = 0; n < TMO && !fetch_en_o; n++) begin
        @(negedge clk_i);
        if (abort_cnt != ab0) low_power_entry_i = 1'b0;
      end
      if (!fetch_en_o) begin
        timeouts++;
        $display("timeout at %0t while waiting for fetch enable to return", $time);
        return;
      end
      check_val(ft_cnt - ft0, exp_ft, "fall through pulses");
      check_val(abort_cnt - ab0, exp_ab, "abort pulses");
      check_val(wkup_cnt - wk0, 1, "wake pulses");
      check_val(hint_cnt - ht0, 1, "hint clear pulses");
    end else begin
      wait_for(W_PWRDN_HIGH, "power down request");
      if (timeouts != 0) return;
      check_val(low_power_o, 1, "low power indication");
      check_val(reset_cause_o, pwrmgr_pkg::LowPwrEntry, "reset cause");
      check_val(rst_lc_req_o[`PWR_DOMAINS-1:1], {(`PWR_DOMAINS-1){~pd}},
                "off domain lc request");
      check_val(rst_sys_req_o, exp_sys, "sys reset request");
      check_val(ft_cnt - ft0 + abort_cnt - ab0, 0, "unexpected fall through or abort");
      check_val(hint_cnt - ht0, 1, "hint clear pulses");
      ack_pwrdn_i = 1'b1;
      low_power_entry_i = 1'b0;
      wait_for(W_PWRDN_LOW, "power down request to drop");
      ack_pwrdn_i = 1'b0;
      if (timeouts != 0) return;
      power_up(1'b1, 1'b1);
    end
    {otp_idle_i, lc_idle_i, flash_idle_i} = 3'b111;
    main_pd_ni = 1'b1;
  endtask

  task automatic run_reset(input logic [`RST_REQ_W-1:0] reqs, input logic dbg,
                           input logic [1:0] exp_sys);
    int n;
    int ht0;
    ht0 = hint_cnt;
    reset_reqs_i = reqs;
    lc_hw_debug_en_i = dbg;
    wait_for(W_CAUSE_HW, "hw reset cause");
    if (timeouts != 0) return;
    check_val(rst_sys_req_o, exp_sys, "sys reset request");
    check_val(rst_lc_req_o, {`PWR_DOMAINS{1'b1}}, "lc reset request");
    check_val(fetch_en_o, 0, "fetch enable in reset");
    check_val(hint_cnt - ht0, 1, "hint clear pulses");
    if (reqs[`RST_MAINPWR_IDX]) begin
      wait_for(W_CLR_SLOW, "slow request clear");
      if (timeouts != 0) return;
      // held in reset while main power request stays
      for (n = 0; n < 6; n++) begin
        @(negedge clk_i);
        check_val(clr_slow_req_o, 1, "slow request clear held");
        check_val(ip_clk_en_o, 0, "clocks held off");
        check_val(rst_lc_req_o, {`PWR_DOMAINS{1'b1}}, "lc reset held");
      end
    end
    reset_reqs_i = '0;
    lc_hw_debug_en_i = 1'b0;
    power_up(1'b0, 1'b0);
  endtask

  initial begin
    int fd;
    int cnt;
    logic [8*8-1:0] kind;
    logic [8*200-1:0] skip_line;
    logic [`RST_REQ_W-1:0] reqs;
    logic pd, lpe, dbg, exp_ab, exp_ft;
    logic [2:0] idle;
    logic [1:0] exp_sys;
    rst_ni = 1'b0;
    req_pwrup_i = 1'b0;
    wake_cause_i = 1'b1;
    ack_pwrdn_i = 1'b0;
    low_power_entry_i = 1'b0;
    main_pd_ni = 1'b1;
    reset_reqs_i = '0;
    lc_hw_debug_en_i = 1'b0;
    rst_lc_src_ni = '0;
    rst_sys_src_ni = '0;
    clk_en_status_i = '0;
    otp_done_i = 1'b0;
    lc_done_i = 1'b0;
    {otp_idle_i, lc_idle_i, flash_idle_i} = 3'b111;
    rom_done_i = 1'b0;
    rom_good_i = 1'b0;
    otp_cnt = '0;
    lc_cnt = '0;
    rom_cnt = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // reset values
    check_val({fetch_en_o, ack_pwrup_o, req_pwrdn_o, otp_init_o, lc_init_o}, 0, "handshakes");
    check_val(ip_clk_en_o, 0, "clock enables");
    check_val({wkup_o, abort_o, fall_through_o, clr_hint_o, clr_slow_req_o, clr_cfg_lock_o},
              0, "pulses");
    check_val(low_power_o, 1, "low power");
    check_val({rst_lc_req_o, rst_sys_req_o}, {(2*`PWR_DOMAINS){1'b1}}, "reset requests");
    check_val(reset_cause_o, pwrmgr_pkg::ResetUndefined, "reset cause");
    power_up(1'b1, 1'b0);
    fd = $fopen("sim/pwrmgr_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test data file");
    end else begin
      cnt = $fgets(skip_line, fd);
      cnt = $fgets(skip_line, fd);
      while (timeouts == 0) begin
        cnt = $fscanf(fd, "%s %h %b %b %b %b %b %b %b\n", kind, reqs, pd, idle, lpe,
                      dbg, exp_sys, exp_ab, exp_ft);
        if (cnt != 9) break;
        if (kind == "lowpwr") run_lowpwr(pd, idle, lpe, exp_sys, exp_ab, exp_ft);
        else run_reset(reqs, dbg, exp_sys);
      end
      $fclose(fd);
    end
    $display("errors=%0d timeouts=%0d assertion_failures=%0d", errors, timeouts,
             uut.u_assertions.fail_count);
    if (errors == 0 && timeouts == 0 && uut.u_assertions.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/pwrmgr_testdata.txt */
# kind reqs(hex) main_pd_n idle(otp,lc,flash) lp_entry hw_dbg_en exp_sys_req
# exp_abort exp_fall_through
lowpwr 00 1 111 1 0 00 0 0
lowpwr 00 0 111 1 0 10 0 0
lowpwr 00 1 111 0 0 00 0 1
lowpwr 00 1 011 1 0 00 1 0
lowpwr 00 1 101 1 0 00 1 0
lowpwr 00 1 110 1 0 00 1 0
reset 01 1 111 0 0 11 0 0
reset 02 1 111 0 0 11 0 0
reset 08 1 111 0 0 11 0 0
reset 04 1 111 0 1 00 0 0
reset 04 1 111 0 0 11 0 0
reset 10 1 111 0 0 11 0 0
reset 20 1 111 0 0 11 0 0
lowpwr 00 0 111 1 0 10 0 0
reset 0c 1 111 0 1 11 0 0
lowpwr 00 1 111 0 0 00 0 1

/* src.f */
+incdir+include
logic/pwrmgr_pkg.sv
logic/pwrmgr_rst_if.sv
logic/pwrmgr_clk_ctrl.sv
logic/pwrmgr_rst_ctrl.sv
logic/pwrmgr_fast_fsm.sv
logic/pwrmgr_top.sv
sim/pwrmgr_assertions.sv
sim/tb_pwrmgr.sv

/* Bender.yml */
package:
  name: pwrmgr

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/pwrmgr_pkg.sv
      - logic/pwrmgr_rst_if.sv
      - logic/pwrmgr_clk_ctrl.sv
      - logic/pwrmgr_rst_ctrl.sv
      - logic/pwrmgr_fast_fsm.sv
      - logic/pwrmgr_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/pwrmgr_assertions.sv
      - sim/tb_pwrmgr.sv
